// File: common/memStagePkg.sv
`default_nettype none

package memStagePkg;

   // datapath width of the processor
   localparam int DATA_W = 16;

   // one data or PC word
   typedef logic [DATA_W-1:0] word_t;

   // wait-state count for the data memory, up to 15 extra cycles
   typedef logic [3:0] waitCnt_t;

   // APB requester sequencing inside the memory stage
   // IDLE waits for a request
   // SETUP is the single psel-only cycle
   // ACCESS holds penable until pready
   // DONE gives the one-cycle completion pulse
   typedef enum logic [1:0] {
      IDLE   = 2'd0,
      SETUP  = 2'd1,
      ACCESS = 2'd2,
      DONE   = 2'd3
   } memState_t;

endpackage

`default_nettype wire

// File: memStage/nextPcUnit.sv
`default_nettype none
`timescale 1ns/1ps

module nextPcUnit (
   input  memStagePkg::word_t pcAdd,
   input  logic               immSrc,
   input  memStagePkg::word_t imm8Ext,
   input  memStagePkg::word_t imm11Ext,
   input  memStagePkg::word_t aluResult,
   input  logic               brchCnd,
   input  logic               aluJump,
   output memStagePkg::word_t finalNewPc,
   output logic               flush
);

   import memStagePkg::*;

   // chosen sign-extended offset
   word_t immSel;
   // incremented pc plus offset
   word_t brTarget;
   // pc after the branch mux, before the jump override
   word_t brPc;

   // immSrc high picks the 11-bit form (jump-style offsets)
   assign immSel = immSrc ? imm11Ext : imm8Ext;

   // carry out dropped, target wraps modulo 2^16
   assign brTarget = pcAdd + immSel;

   // taken branch goes to the target, otherwise fall through
   assign brPc = brchCnd ? brTarget : pcAdd;

   // register jumps come from the ALU and win over any branch
   assign finalNewPc = aluJump ? aluResult : brPc;

   // any redirect kills the younger instructions
   assign flush = brchCnd | aluJump;

endmodule

`default_nettype wire

// File: memStage/memAccessCtrl.sv
`default_nettype none
`timescale 1ns/1ps

module memAccessCtrl #(
   parameter int MEM_ADDR_W = 8
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  opValid,
   input  logic                  memReadorWrite,
   input  logic                  memWrite,
   input  memStagePkg::word_t    aluResult,
   input  memStagePkg::word_t    writeData,
   output logic                  psel,
   output logic                  penable,
   output logic                  pwrite,
   output logic [MEM_ADDR_W-1:0] paddr,
   output memStagePkg::word_t    pwdata,
   input  memStagePkg::word_t    prdata,
   input  logic                  pready,
   output memStagePkg::word_t    readData,
   output logic                  stall,
   output logic                  opDone
);

   import memStagePkg::*;

   memState_t state;
   memState_t nextState;

   // new request taken only from IDLE
   logic accept;
   // last edge of the APB transfer
   logic complete;

   // request fields held stable for the whole transfer
   logic [MEM_ADDR_W-1:0] addrQ;
   logic                  writeQ;
   word_t                 wdataQ;

   assign accept   = (state == IDLE) && opValid && memReadorWrite;
   assign complete = (state == ACCESS) && pready;

   always_comb begin
      nextState = state;
      case (state)
         IDLE: begin
            if (accept) begin
               nextState = SETUP;
            end
         end
         SETUP: begin
            nextState = ACCESS;
         end
         ACCESS: begin
            // completer may stretch this with wait states
            if (pready) begin
               nextState = DONE;
            end
         end
         DONE: begin
            nextState = IDLE;
         end
         default: begin
            nextState = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
      end else begin
         state <= nextState;
      end
   end

   // latch on acceptance, word index drops bit 0
   always_ff @(posedge clk) begin
      if (accept) begin
         addrQ  <= aluResult[MEM_ADDR_W:1];
         writeQ <= memWrite;
         wdataQ <= writeData;
      end
   end

   // read result held until the next read finishes
   always_ff @(posedge clk) begin
      if (rst) begin
         readData <= '0;
      end else if (complete && !writeQ) begin
         readData <= prdata;
      end
   end

   // APB requester outputs
   assign psel    = (state == SETUP) || (state == ACCESS);
   assign penable = (state == ACCESS);
   assign pwrite  = writeQ;
   assign paddr   = addrQ;
   assign pwdata  = wdataQ;

   // stall starts in the request cycle itself, before the FSM moves
   assign stall  = accept || (state == SETUP) || (state == ACCESS);
   assign opDone = (state == DONE);

endmodule

`default_nettype wire

// File: memStage/waitTimer.sv
`default_nettype none
`timescale 1ns/1ps

module waitTimer (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  load,
   input  memStagePkg::waitCnt_t loadValue,
   output logic                  done
);

   import memStagePkg::*;

   // cycles still to wait
   waitCnt_t count;
   // counting in progress
   logic busy;

   always_ff @(posedge clk) begin
      if (rst) begin
         count <= '0;
         busy  <= 1'b0;
      end else if (load) begin
         count <= loadValue;
         // zero load means nothing to wait for
         busy  <= (loadValue != '0);
      end else if (busy) begin
         count <= count - 1'b1;
         // last step, drop busy as count hits zero
         busy  <= (count != 4'd1);
      end
   end

   // idle with nothing left
   assign done = !busy && (count == '0);

endmodule

`default_nettype wire

// File: memStage/dataMem.sv
`default_nettype none
`timescale 1ns/1ps

module dataMem #(
   parameter int                    MEM_ADDR_W  = 8,
   parameter memStagePkg::waitCnt_t WAIT_STATES = 4'd2
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [MEM_ADDR_W-1:0] paddr,
   input  memStagePkg::word_t    pwdata,
   output memStagePkg::word_t    prdata,
   output logic                  pready
);

   import memStagePkg::*;

   localparam int DEPTH = 1 << MEM_ADDR_W;

   // word array, one entry per word index
   word_t mem [DEPTH];

   // setup phase, arms the wait timer
   logic setupPhase;
   // access phase, waiting on the timer
   logic accessPhase;
   // transfer finishes on this edge
   logic complete;
   logic timerDone;

   assign setupPhase  = psel && !penable;
   assign accessPhase = psel && penable;

   // timer reloads every SETUP so each transfer gets the full latency
   waitTimer u_waitTimer (
      .clk       (clk),
      .rst       (rst),
      .load      (setupPhase),
      .loadValue (WAIT_STATES),
      .done      (timerDone)
   );

   // with zero wait states, ready in the first ACCESS cycle
   assign pready   = accessPhase && timerDone;
   assign complete = pready;

   // memory starts from all zeros
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (complete && pwrite) begin
         mem[paddr] <= pwdata;
      end
   end

   // read data only presented on the completing cycle of a read
   assign prdata = (complete && !pwrite) ? mem[paddr] : '0;

endmodule

`default_nettype wire

// File: memStage/memStage.sv
`default_nettype none
`timescale 1ns/1ps

module memStage #(
   parameter int                    MEM_ADDR_W  = 8,
   parameter memStagePkg::waitCnt_t WAIT_STATES = 4'd2
) (
   input  logic               clk,
   input  logic               rst,
   input  memStagePkg::word_t pcAdd,
   input  logic               immSrc,
   input  memStagePkg::word_t imm8Ext,
   input  memStagePkg::word_t imm11Ext,
   input  memStagePkg::word_t aluResult,
   input  logic               aluJump,
   input  logic               brchCnd,
   input  logic               memReadorWrite,
   input  logic               memWrite,
   input  memStagePkg::word_t writeData,
   input  logic               opValid,
   output memStagePkg::word_t finalNewPc,
   output logic               flush,
   output memStagePkg::word_t readData,
   output logic               stall,
   output logic               opDone
);

   import memStagePkg::*;

   // APB link between the requester and the memory
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [MEM_ADDR_W-1:0] paddr;
   word_t                 pwdata;
   word_t                 prdata;
   logic                  pready;

   // pc path, purely combinational
   nextPcUnit u_nextPcUnit (
      .pcAdd      (pcAdd),
      .immSrc     (immSrc),
      .imm8Ext    (imm8Ext),
      .imm11Ext   (imm11Ext),
      .aluResult  (aluResult),
      .brchCnd    (brchCnd),
      .aluJump    (aluJump),
      .finalNewPc (finalNewPc),
      .flush      (flush)
   );

   // requester, also owns stall and readData
   memAccessCtrl #(
      .MEM_ADDR_W (MEM_ADDR_W)
   ) u_memAccessCtrl (
      .clk            (clk),
      .rst            (rst),
      .opValid        (opValid),
      .memReadorWrite (memReadorWrite),
      .memWrite       (memWrite),
      .aluResult      (aluResult),
      .writeData      (writeData),
      .psel           (psel),
      .penable        (penable),
      .pwrite         (pwrite),
      .paddr          (paddr),
      .pwdata         (pwdata),
      .prdata         (prdata),
      .pready         (pready),
      .readData       (readData),
      .stall          (stall),
      .opDone         (opDone)
   );

   // completer with configurable wait states
   dataMem #(
      .MEM_ADDR_W  (MEM_ADDR_W),
      .WAIT_STATES (WAIT_STATES)
   ) u_dataMem (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready)
   );

endmodule

`default_nettype wire

// File: tests/tbClockGen.sv
`default_nettype none
`timescale 1ns/1ps

module tbClockGen #(
   parameter int PERIOD_NS    = 8,
   parameter int RESET_CYCLES = 16
) (
   output logic clk,
   output logic rst
);

   // free-running clock, starts low
   initial begin
      clk = 1'b0;
   end

   always #(PERIOD_NS / 2.0) clk = ~clk;

   // reset high from time zero, dropped on a rising edge
   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
   end

endmodule

`default_nettype wire

// File: tests/memStageTb.sv
`default_nettype none
`timescale 1ns/1ps

module memStageTb;

   import memStagePkg::*;

   localparam int ADDR_W       = 8;
   localparam int MEM_WORDS    = 1 << ADDR_W;
   localparam int DONE_TIMEOUT = 100;
   localparam int IDLE_WATCH   = 10;
   localparam int RANDOM_OPS   = 200;

   logic  clk;
   logic  rst;

   // stage inputs, played by the tb as the pipeline register
   word_t pcAdd;
   logic  immSrc;
   word_t imm8Ext;
   word_t imm11Ext;
   word_t aluResult;
   logic  aluJump;
   logic  brchCnd;
   logic  memReadorWrite;
   logic  memWrite;
   word_t writeData;
   logic  opValid;

   // stage outputs
   word_t finalNewPc;
   logic  flush;
   word_t readData;
   logic  stall;
   logic  opDone;

   // expected memory contents, indexed by word
   word_t shadow [MEM_WORDS];
   // readData should hold this between reads
   word_t lastRead;
   // running op number, shown in error lines
   int    opCount;

   tbClockGen #(
      .PERIOD_NS    (8),
      .RESET_CYCLES (16)
   ) u_clockGen (
      .clk (clk),
      .rst (rst)
   );

   memStage u_dut (
      .clk            (clk),
      .rst            (rst),
      .pcAdd          (pcAdd),
      .immSrc         (immSrc),
      .imm8Ext        (imm8Ext),
      .imm11Ext       (imm11Ext),
      .aluResult      (aluResult),
      .aluJump        (aluJump),
      .brchCnd        (brchCnd),
      .memReadorWrite (memReadorWrite),
      .memWrite       (memWrite),
      .writeData      (writeData),
      .opValid        (opValid),
      .finalNewPc     (finalNewPc),
      .flush          (flush),
      .readData       (readData),
      .stall          (stall),
      .opDone         (opDone)
   );

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("** FAIL **");
      $fatal(1);
   endtask

   task automatic checkWord(input string name, input word_t expected, input word_t actual);
      if (actual !== expected) begin
         reportFailure($sformatf("Mismatch %s expected 0x%h actual 0x%h (op %0d)",
                                 name, expected, actual, opCount));
      end
   endtask

   task automatic checkBit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         reportFailure($sformatf("Mismatch %s expected 0x%h actual 0x%h (op %0d)",
                                 name, expected, actual, opCount));
      end
   endtask

   // stall must stay up until the completion pulse
   task automatic waitOpDone();
      int cycles;
      cycles = 0;
      forever begin
         @(negedge clk);
         if (opDone) begin
            break;
         end
         checkBit("stall", 1'b1, stall);
         cycles++;
         if (cycles >= DONE_TIMEOUT) begin
            reportFailure($sformatf("timed out waiting for opDone on op %0d", opCount));
         end
      end
   endtask

   // a non-memory op must stay invisible to the memory side
   task automatic watchNoDone();
      int cycles;
      for (cycles = 0; cycles < IDLE_WATCH; cycles++) begin
         @(negedge clk);
         if (opDone) begin
            reportFailure($sformatf("opDone was raised by non-memory op %0d", opCount));
         end
         checkBit("stall", 1'b0, stall);
      end
   endtask

   task automatic waitResetRelease();
      int cycles;
      cycles = 0;
      while (rst) begin
         @(posedge clk);
         cycles++;
         if (cycles > 100) begin
            reportFailure("reset was not released within 100 cycles");
         end
      end
      @(negedge clk);
   endtask

   // one pipeline op, fields held until the next one
   task automatic runOp(
      input word_t pc,
      input logic  iSrc,
      input word_t i8,
      input word_t i11,
      input word_t alu,
      input logic  br,
      input logic  jmp,
      input logic  mrw,
      input logic  mw,
      input word_t wd,
      input word_t expPc,
      input logic  expFlush
   );
      opCount++;
      @(posedge clk);
      pcAdd          <= pc;
      immSrc         <= iSrc;
      imm8Ext        <= i8;
      imm11Ext       <= i11;
      aluResult      <= alu;
      brchCnd        <= br;
      aluJump        <= jmp;
      memReadorWrite <= mrw;
      memWrite       <= mw;
      writeData      <= wd;
      opValid        <= 1'b1;
      // pc path and the early stall settle within the cycle
      @(negedge clk);
      checkWord("finalNewPc", expPc, finalNewPc);
      checkBit("flush", expFlush, flush);
      checkBit("stall", mrw, stall);
      @(posedge clk);
      opValid <= 1'b0;
      if (mrw) begin
         waitOpDone();
      end else begin
         watchNoDone();
      end
   endtask

   task automatic readVectors();
      int    fd;
      int    n;
      int    kind;
      string line;
      word_t vPc;
      word_t vImm8;
      word_t vImm11;
      word_t vAlu;
      word_t vWd;
      word_t vExpPc;
      word_t vExpRead;
      logic  vISrc;
      logic  vBr;
      logic  vJmp;
      logic  vMrw;
      logic  vMw;
      logic  vExpFlush;
      fd = $fopen("tests/memStageInput.txt", "r");
      if (fd == 0) begin
         reportFailure("could not open tests/memStageInput.txt");
      end
      while ($fgets(line, fd) != 0) begin
         // blank lines and column notes
         if (line.len() <= 1 || line.substr(0, 1) == "//") begin
            continue;
         end
         n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     kind, vPc, vISrc, vImm8, vImm11, vAlu, vBr, vJmp,
                     vMrw, vMw, vWd, vExpPc, vExpFlush, vExpRead);
         if (n != 14) begin
            reportFailure($sformatf("vector line has %0d fields instead of 14", n));
         end
         // kind 0 is no memory, 1 a write, 2 a read
         if (kind != (vMrw ? (vMw ? 1 : 2) : 0)) begin
            reportFailure("vector kind does not match its memory control fields");
         end
         runOp(vPc, vISrc, vImm8, vImm11, vAlu, vBr, vJmp, vMrw, vMw, vWd,
               vExpPc, vExpFlush);
         if (vMrw && vMw) begin
            shadow[vAlu[ADDR_W:1]] = vWd;
         end
         lastRead = vExpRead;
         checkWord("readData", vExpRead, readData);
      end
      $fclose(fd);
   endtask

   task automatic randomTraffic();
      int    i;
      int    idx;
      logic  isWrite;
      word_t alu;
      word_t wd;
      word_t pc;
      word_t expRead;
      for (i = 0; i < RANDOM_OPS; i++) begin
         idx     = $urandom % MEM_WORDS;
         isWrite = ($urandom % 2) == 1;
         // random upper bits and bit 0 must not matter
         alu     = word_t'($urandom);
         alu[ADDR_W:1] = ADDR_W'(idx);
         wd      = word_t'($urandom);
         pc      = word_t'($urandom);
         runOp(pc, 1'b0, 16'h0000, 16'h0000, alu, 1'b0, 1'b0, 1'b1, isWrite, wd,
               pc, 1'b0);
         if (isWrite) begin
            shadow[idx] = wd;
            expRead     = lastRead;
         end else begin
            expRead = shadow[idx];
         end
         lastRead = expRead;
         checkWord("readData", expRead, readData);
      end
   endtask

   // read back every word once
   task automatic sweepReads();
      int    i;
      word_t alu;
      for (i = 0; i < MEM_WORDS; i++) begin
         alu = word_t'(i << 1);
         runOp(16'h0200, 1'b0, 16'h0000, 16'h0000, alu, 1'b0, 1'b0, 1'b1, 1'b0,
               16'h0000, 16'h0200, 1'b0);
         checkWord("readData", shadow[i], readData);
      end
   endtask

   initial begin : mainFlow
      int unsigned seedInit;
      seedInit       = $urandom(8);
      opCount        = 0;
      lastRead       = '0;
      for (int i = 0; i < MEM_WORDS; i++) begin
         shadow[i] = '0;
      end
      pcAdd          <= '0;
      immSrc         <= 1'b0;
      imm8Ext        <= '0;
      imm11Ext       <= '0;
      aluResult      <= '0;
      aluJump        <= 1'b0;
      brchCnd        <= 1'b0;
      memReadorWrite <= 1'b0;
      memWrite       <= 1'b0;
      writeData      <= '0;
      opValid        <= 1'b0;
      waitResetRelease();
      // quiet state straight out of reset
      checkBit("stall", 1'b0, stall);
      checkBit("opDone", 1'b0, opDone);
      checkWord("readData", 16'h0000, readData);
      readVectors();
      randomTraffic();
      sweepReads();
      $display("** PASS **");
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/memStageInput.txt
// kind(0 none 1 write 2 read) pcAdd immSrc imm8Ext imm11Ext aluResult brchCnd aluJump
// memReadorWrite memWrite writeData expPc expFlush expReadData, all but kind in hex
// taken branches with the 8-bit and 11-bit offsets
0 0010 0 0005 0123 0000 1 0 0 0 0000 0015 1 0000
0 0010 1 0005 0123 0000 1 0 0 0 0000 0133 1 0000
0 0020 0 FFFC 0000 0000 1 0 0 0 0000 001C 1 0000
0 0100 1 0005 FC00 0000 1 0 0 0 0000 FD00 1 0000
0 FFF0 0 0020 0000 0000 1 0 0 0 0000 0010 1 0000
0 8000 1 0000 8000 0000 1 0 0 0 0000 0000 1 0000
// not taken, fall through
0 1234 0 0005 0123 0000 0 0 0 0 0000 1234 0 0000
0 1234 1 0005 0123 0000 0 0 0 0 0000 1234 0 0000
// jumps override branch and offset select
0 1234 0 0005 0123 4000 0 1 0 0 0000 4000 1 0000
0 1234 1 0005 0123 8ABC 1 1 0 0 0000 8ABC 1 0000
0 0002 0 00FF 07FF 0042 1 1 0 0 0000 0042 1 0000
// never-written word reads zero
2 0040 0 0000 0000 0010 0 0 1 0 0000 0040 0 0000
// write then read through the aliased address
1 0042 0 0000 0000 0010 0 0 1 1 BEEF 0042 0 0000
2 0044 0 0000 0000 0011 0 0 1 0 0000 0044 0 BEEF
// read data held across a write and a plain op
1 0046 0 0003 0000 0020 1 0 1 1 1234 0049 1 BEEF
0 0048 0 0000 0000 0020 0 0 0 0 0000 0048 0 BEEF
2 004A 0 0000 0000 0021 0 0 1 0 0000 004A 0 1234
// first and last words
1 004C 0 0000 0000 01FE 0 0 1 1 A5A5 004C 0 1234
1 004E 0 0000 0000 0000 0 0 1 1 5A5A 004E 0 1234
2 0050 0 0000 0000 0001 0 0 1 0 0000 0050 0 5A5A
2 0052 0 0000 0000 01FF 0 0 1 0 0000 0052 0 A5A5
// high address bits ignored, jump during a read
2 0054 0 0000 0000 FE10 0 1 1 0 0000 FE10 1 BEEF
// overwrite and read back
1 0056 1 0000 0010 0011 0 0 1 1 0F0F 0056 0 BEEF
2 0058 0 0000 0000 0010 0 0 1 0 0000 0058 0 0F0F
2 005A 0 0000 0000 0030 0 0 1 0 0000 005A 0 0000
// branch with no memory access
0 0100 1 0000 0010 0020 1 0 0 0 0000 0110 1 0000

// File: build.f
common/memStagePkg.sv
memStage/nextPcUnit.sv
memStage/memAccessCtrl.sv
memStage/waitTimer.sv
memStage/dataMem.sv
memStage/memStage.sv
tests/tbClockGen.sv
tests/memStageTb.sv
